// ==== tb.f ====
design/csr_pkg.sv
design/csr_update_arbiter.sv
design/priv_mode_ctrl.sv
design/m_trap_csrs.sv
design/s_trap_csrs.sv
design/csr_timer.sv
design/csr_read_mux.sv
design/csr_regfile.sv
tb/tb_csr_regfile.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -j 0 --top-module tb_csr_regfile -f tb.f \
	&& ./obj_dir/Vtb_csr_regfile | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// ==== tb/tb_csr_regfile.sv ====
`default_nettype none

module tb_csr_regfile;

	localparam logic [31:0] hart_id = 32'h0000_0005;

	logic                     clk = 1'b0;
	logic                     nrst;
	csr_pkg::csr_write_t      wr;
	csr_pkg::trap_req_t       trap;
	csr_pkg::csr_addr_e       csr_address_r;
	logic                     m_interrupt;
	logic                     s_interrupt;
	logic [csr_pkg::xlen-1:0] csr_data;
	logic [csr_pkg::xlen-1:0] epc;
	csr_pkg::priv_mode_e      current_mode;
	csr_pkg::irq_enable_t     irq_en;
	logic                     m_timer;
	logic                     s_timer;

	string       cur_test;
	int          errors;
	int          checks;
	int          tests;
	int          errors_at_start;
	logic [31:0] mtvec_val; // vector base as last written
	logic [31:0] mepc_val;
	logic [31:0] sepc_val;

	csr_regfile #(
		.hart_id(hart_id)
	) u_dut (.*);

	initial
	begin
		forever #4 clk = ~clk;
	end

	task automatic start_test(input string name);
		cur_test = name;
		errors_at_start = errors;
		tests++;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start)
			$display("test %s ok", cur_test);
		else
			$display("test %s had %0d errors", cur_test, errors - errors_at_start);
	endtask

	task automatic check_data(input string what, input logic [csr_pkg::xlen-1:0] exp,
		input logic [csr_pkg::xlen-1:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_mode(input string what, input csr_pkg::priv_mode_e exp,
		input csr_pkg::priv_mode_e act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s expected %s actual %s", cur_test, what, exp.name(), act.name());
		end
	endtask

	task automatic check_irq(input string what, input csr_pkg::irq_enable_t exp,
		input csr_pkg::irq_enable_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	// reads are combinational and sampled just after the falling edge
	task automatic read_csr(input csr_pkg::csr_addr_e addr, output logic [31:0] data);
		@(negedge clk);
		csr_address_r = addr;
		#1;
		data = csr_data;
	endtask

	task automatic expect_csr(input csr_pkg::csr_addr_e addr, input logic [31:0] exp,
		input string what);
		logic [31:0] data;
		read_csr(addr, data);
		check_data(what, exp, data);
	endtask

	task automatic write_csr(input csr_pkg::csr_addr_e addr, input logic [31:0] data);
		@(negedge clk);
		wr.we = 1'b1;
		wr.addr = addr;
		wr.data = data;
		@(negedge clk);
		wr.we = 1'b0;
	endtask

	task automatic raise_trap(input logic [31:0] cause, input logic [31:0] pc);
		@(negedge clk);
		trap.exception_pending = 1'b1;
		trap.cause = cause;
		trap.pc_exc = pc;
		@(negedge clk);
		trap.exception_pending = 1'b0;
	endtask

	// one-cycle mret or sret with epc checked while the strobe is up
	task automatic pulse_return(input logic is_m, input logic [31:0] exp_epc);
		@(negedge clk);
		trap.m_ret = is_m;
		trap.s_ret = !is_m;
		#1;
		check_data("epc during return", exp_epc, epc);
		@(negedge clk);
		trap.m_ret = 1'b0;
		trap.s_ret = 1'b0;
	endtask

	task automatic test_reset_state();
		start_test("reset_state");
		expect_csr(csr_pkg::csr_misa, csr_pkg::misa_value, "misa");
		expect_csr(csr_pkg::csr_mhartid, hart_id, "mhartid");
		expect_csr(csr_pkg::csr_mstatus, 32'h0000_1800, "mstatus");
		check_mode("mode", csr_pkg::mode_m, current_mode);
		check_data("timer flags", 32'd0, {30'd0, m_timer, s_timer});
		check_irq("irq_en", '0, irq_en);
		finish_test();
	endtask

	task automatic test_write_masks();
		logic [31:0] v;
		start_test("write_masks");
		write_csr(csr_pkg::csr_mstatus, 32'hffff_ffff);
		expect_csr(csr_pkg::csr_mstatus, 32'h0004_19aa, "mstatus");
		expect_csr(csr_pkg::csr_sstatus, 32'h0004_0122, "sstatus");
		v = $urandom;
		write_csr(csr_pkg::csr_mtvec, v);
		mtvec_val = v & ~32'h3;
		expect_csr(csr_pkg::csr_mtvec, mtvec_val, "mtvec");
		v = $urandom;
		write_csr(csr_pkg::csr_mscratch, v);
		expect_csr(csr_pkg::csr_mscratch, v, "mscratch");
		finish_test();
	endtask

	task automatic test_trap_m();
		logic [31:0] cause;
		logic [31:0] pc;
		start_test("trap_m_from_m");
		write_csr(csr_pkg::csr_mstatus, 32'h0000_0008); // mie set and mpp U
		cause = $urandom;
		pc = $urandom;
		raise_trap(cause, pc);
		mepc_val = pc & ~32'h3;
		expect_csr(csr_pkg::csr_mepc, mepc_val, "mepc");
		expect_csr(csr_pkg::csr_mcause, cause, "mcause");
		expect_csr(csr_pkg::csr_mstatus, 32'h0000_1880, "mstatus");
		check_data("epc", mtvec_val, epc);
		check_mode("mode", csr_pkg::mode_m, current_mode);
		finish_test();
	endtask

	task automatic test_delegation();
		logic [31:0] pc;
		start_test("delegation");
		write_csr(csr_pkg::csr_medeleg, 32'h0000_0100); // ecall from U
		write_csr(csr_pkg::csr_mstatus, 32'h0000_0800);
		pulse_return(1'b1, mepc_val);
		check_mode("mode after mret", csr_pkg::mode_s, current_mode);
		pc = $urandom;
		raise_trap(32'd8, pc);
		sepc_val = pc & ~32'h3;
		check_mode("mode after cause 8", csr_pkg::mode_s, current_mode);
		expect_csr(csr_pkg::csr_sepc, sepc_val, "sepc");
		expect_csr(csr_pkg::csr_scause, 32'd8, "scause");
		pc = $urandom;
		raise_trap(32'd2, pc); // not delegated
		mepc_val = pc & ~32'h3;
		check_mode("mode after cause 2", csr_pkg::mode_m, current_mode);
		expect_csr(csr_pkg::csr_mcause, 32'd2, "mcause");
		expect_csr(csr_pkg::csr_mepc, mepc_val, "mepc");
		finish_test();
	endtask

	task automatic test_sret();
		start_test("sret");
		pulse_return(1'b1, mepc_val); // mpp still S
		check_mode("mode after mret", csr_pkg::mode_s, current_mode);
		write_csr(csr_pkg::csr_sstatus, 32'h0000_0002); // sie set with spie and spp clear
		pulse_return(1'b0, sepc_val);
		check_mode("mode after sret", csr_pkg::mode_u, current_mode);
		expect_csr(csr_pkg::csr_sstatus, 32'h0000_0020, "sstatus");
		finish_test();
	endtask

	task automatic test_timer_irq();
		logic [31:0]          t;
		logic [31:0]          cmp;
		int                   n;
		csr_pkg::irq_enable_t exp_irq;
		start_test("timer_irq");
		read_csr(csr_pkg::csr_time, t);
		cmp = t + 32'd20;
		write_csr(csr_pkg::csr_mtimecmp, cmp);
		n = 0;
		while (!m_timer && n < 200)
		begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (!m_timer)
		begin
			errors++;
			$display("%s: m_timer did not rise within 200 cycles", cur_test);
		end
		read_csr(csr_pkg::csr_time, t);
		checks++;
		if (t < cmp)
		begin
			errors++;
			$display("%s: time %0d is still below the compare value %0d", cur_test, t, cmp);
		end
		write_csr(csr_pkg::csr_mie, 32'h0000_0080);
		write_csr(csr_pkg::csr_mstatus, 32'h0000_0008);
		exp_irq = '{m_eie: 1'b0, m_tie: 1'b1, s_eie: 1'b0, s_tie: 1'b0};
		check_irq("irq_en", exp_irq, irq_en);
		expect_csr(csr_pkg::csr_mip, 32'h0000_0080, "mip");
		finish_test();
	endtask

	initial
	begin
		void'($urandom(37));
		errors = 0;
		checks = 0;
		tests = 0;
		nrst = 1'b0;
		wr = '0;
		trap = '0;
		csr_address_r = csr_pkg::csr_misa;
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;
		repeat (5) @(negedge clk);
		nrst = 1'b1;
		test_reset_state();
		test_write_masks();
		test_trap_m();
		test_delegation();
		test_sret();
		test_timer_irq();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/csr_regfile.sv ====
`default_nettype none

module csr_regfile #(
	parameter logic [31:0] hart_id = 32'd0
) (
	input  logic                     clk,
	input  logic                     nrst,
	input  csr_pkg::csr_write_t      wr,
	input  csr_pkg::trap_req_t       trap,
	input  csr_pkg::csr_addr_e       csr_address_r,
	input  logic                     m_interrupt,
	input  logic                     s_interrupt,
	output logic [csr_pkg::xlen-1:0] csr_data,
	output logic [csr_pkg::xlen-1:0] epc,
	output csr_pkg::priv_mode_e      current_mode,
	output csr_pkg::irq_enable_t     irq_en,
	output logic                     m_timer,
	output logic                     s_timer
);

	csr_pkg::csr_update_t     upd;
	csr_pkg::priv_mode_e      target;
	csr_pkg::m_view_t         m_view;
	csr_pkg::s_view_t         s_view;
	logic                     s_sie;
	logic [63:0]              mtime;
	logic [csr_pkg::xlen-1:0] mtimecmp;
	logic [csr_pkg::xlen-1:0] stimecmp;

	csr_update_arbiter u_arbiter (.*);

	priv_mode_ctrl u_mode (.*);

	m_trap_csrs u_m_bank (
		.sepc(s_view.sepc),
		.*
	);

	s_trap_csrs u_s_bank (.*);

	csr_timer u_timer (.*);

	csr_read_mux #(
		.hart_id(hart_id)
	) u_read_mux (.*);

endmodule

`default_nettype wire

// ==== design/csr_read_mux.sv ====
`default_nettype none

module csr_read_mux #(
	parameter logic [31:0] hart_id = 32'd0
) (
	input  csr_pkg::csr_addr_e       csr_address_r,
	input  csr_pkg::m_view_t         m_view,
	input  csr_pkg::s_view_t         s_view,
	input  logic [63:0]              mtime,
	input  logic [csr_pkg::xlen-1:0] mtimecmp,
	input  logic [csr_pkg::xlen-1:0] stimecmp,
	input  logic                     m_timer,
	input  logic                     s_timer,
	input  logic                     m_interrupt,
	input  logic                     s_interrupt,
	output logic [csr_pkg::xlen-1:0] csr_data
);

	always_comb
	begin
		case (csr_address_r)
			csr_pkg::csr_misa:    csr_data = csr_pkg::misa_value;
			csr_pkg::csr_mhartid: csr_data = hart_id;
			csr_pkg::csr_mstatus:
				csr_data = {13'b0, m_view.sum, 5'b0, m_view.mpp, 2'b0, s_view.spp,
					m_view.mpie, 1'b0, s_view.spie, 1'b0, m_view.mie, 1'b0, s_view.sie, 1'b0};
			csr_pkg::csr_mie:
				csr_data = {20'b0, m_view.meie, 1'b0, m_view.seie, 1'b0,
					m_view.mtie, 1'b0, m_view.stie, 5'b0};
			csr_pkg::csr_mip:
				csr_data = {20'b0, m_interrupt, 1'b0, s_interrupt, 1'b0,
					m_timer, 1'b0, s_timer, 5'b0};
			csr_pkg::csr_mtvec:    csr_data = {m_view.mtvec, 2'b00}; // direct mode only
			csr_pkg::csr_mepc:     csr_data = m_view.mepc;
			csr_pkg::csr_mcause:   csr_data = m_view.mcause;
			csr_pkg::csr_mscratch: csr_data = m_view.mscratch;
			csr_pkg::csr_medeleg:  csr_data = {16'b0, m_view.medeleg};
			csr_pkg::csr_mideleg:  csr_data = {20'b0, m_view.mideleg};
			csr_pkg::csr_mtimecmp: csr_data = mtimecmp;
			// supervisor views
			csr_pkg::csr_sstatus:
				csr_data = {13'b0, m_view.sum, 9'b0, s_view.spp, 2'b0,
					s_view.spie, 3'b0, s_view.sie, 1'b0};
			csr_pkg::csr_sie:      csr_data = {22'b0, m_view.seie, 3'b0, m_view.stie, 5'b0};
			csr_pkg::csr_sip:      csr_data = {22'b0, s_interrupt, 3'b0, s_timer, 5'b0};
			csr_pkg::csr_stvec:    csr_data = {s_view.stvec, 2'b00};
			csr_pkg::csr_sepc:     csr_data = s_view.sepc;
			csr_pkg::csr_scause:   csr_data = s_view.scause;
			csr_pkg::csr_sscratch: csr_data = s_view.sscratch;
			csr_pkg::csr_stimecmp: csr_data = stimecmp;
			// cycle shares the time counter
			csr_pkg::csr_time, csr_pkg::csr_cycle:   csr_data = mtime[31:0];
			csr_pkg::csr_timeh, csr_pkg::csr_cycleh: csr_data = mtime[63:32];
			default:               csr_data = '0; // ids and unknown addresses
		endcase
	end

endmodule

`default_nettype wire

// ==== design/csr_timer.sv ====
`default_nettype none

module csr_timer (
	input  logic                     clk,
	input  logic                     nrst,
	input  csr_pkg::csr_update_t     upd,
	output logic [63:0]              mtime,
	output logic [csr_pkg::xlen-1:0] mtimecmp,
	output logic [csr_pkg::xlen-1:0] stimecmp,
	output logic                     m_timer,
	output logic                     s_timer
);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtime    <= '0;
			// compares start at the top so nothing is pending out of reset
			mtimecmp <= '1;
			stimecmp <= '1;
			m_timer  <= 1'b0;
			s_timer  <= 1'b0;
		end
		else
		begin
			mtime   <= mtime + 64'd1;
			m_timer <= mtime >= {32'b0, mtimecmp};
			s_timer <= mtime >= {32'b0, stimecmp};
			if (upd.kind == csr_pkg::upd_write)
			begin
				case (upd.addr)
					csr_pkg::csr_mtimecmp: mtimecmp <= upd.data;
					csr_pkg::csr_stimecmp: stimecmp <= upd.data;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/s_trap_csrs.sv ====
`default_nettype none

module s_trap_csrs (
	input  logic                 clk,
	input  logic                 nrst,
	input  csr_pkg::csr_update_t upd,
	input  csr_pkg::priv_mode_e  current_mode,
	output csr_pkg::s_view_t     s_view,
	output logic                 s_sie
);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			s_view <= '0;
		else
		begin
			case (upd.kind)
				csr_pkg::upd_trap:
				begin
					if (upd.target == csr_pkg::mode_s)
					begin
						s_view.sepc   <= {upd.pc[csr_pkg::xlen-1:2], 2'b00};
						s_view.scause <= upd.cause;
						s_view.spie   <= s_view.sie;
						s_view.sie    <= 1'b0;
						s_view.spp    <= current_mode[0]; // U or S only here
					end
				end
				csr_pkg::upd_sret:
				begin
					s_view.sie  <= s_view.spie;
					s_view.spie <= 1'b1;
					s_view.spp  <= 1'b0;
				end
				csr_pkg::upd_write:
				begin
					case (upd.addr)
						csr_pkg::csr_mstatus, csr_pkg::csr_sstatus:
						begin
							s_view.sie  <= upd.data[1];
							s_view.spie <= upd.data[5];
							s_view.spp  <= upd.data[8];
						end
						csr_pkg::csr_stvec:    s_view.stvec <= upd.data[csr_pkg::xlen-1:2];
						csr_pkg::csr_sepc:     s_view.sepc <= {upd.data[csr_pkg::xlen-1:2], 2'b00};
						csr_pkg::csr_scause:   s_view.scause <= upd.data;
						csr_pkg::csr_sscratch: s_view.sscratch <= upd.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	assign s_sie = s_view.sie; // global S enable for the irq gating

endmodule

`default_nettype wire

// ==== design/m_trap_csrs.sv ====
`default_nettype none

module m_trap_csrs (
	input  logic                      clk,
	input  logic                      nrst,
	input  csr_pkg::csr_update_t      upd,
	input  csr_pkg::priv_mode_e       current_mode,
	input  logic                      s_sie,
	input  logic [csr_pkg::xlen-1:0]  sepc,
	output csr_pkg::m_view_t          m_view,
	output csr_pkg::irq_enable_t      irq_en,
	output logic [csr_pkg::xlen-1:0]  epc
);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			m_view     <= '0;
			m_view.mpp <= csr_pkg::mode_m;
		end
		else
		begin
			case (upd.kind)
				csr_pkg::upd_trap:
				begin
					if (upd.target == csr_pkg::mode_m)
					begin
						m_view.mepc   <= {upd.pc[csr_pkg::xlen-1:2], 2'b00};
						m_view.mcause <= upd.cause;
						m_view.mpie   <= m_view.mie;
						m_view.mie    <= 1'b0; // interrupts off on entry
						m_view.mpp    <= current_mode;
					end
				end
				csr_pkg::upd_mret:
				begin
					m_view.mie  <= m_view.mpie;
					m_view.mpie <= 1'b1;
					m_view.mpp  <= csr_pkg::mode_u;
				end
				csr_pkg::upd_write:
				begin
					case (upd.addr)
						csr_pkg::csr_mstatus:
						begin
							m_view.mie  <= upd.data[3];
							m_view.mpie <= upd.data[7];
							// reserved mpp encoding falls back to U
							m_view.mpp  <= (upd.data[12:11] == 2'b10) ? csr_pkg::mode_u
								: csr_pkg::priv_mode_e'(upd.data[12:11]);
							m_view.sum  <= upd.data[18];
						end
						csr_pkg::csr_sstatus: m_view.sum <= upd.data[18];
						csr_pkg::csr_mie:
						begin
							m_view.stie <= upd.data[5];
							m_view.mtie <= upd.data[7];
							m_view.seie <= upd.data[9];
							m_view.meie <= upd.data[11];
						end
						csr_pkg::csr_sie:
						begin
							m_view.stie <= upd.data[5];
							m_view.seie <= upd.data[9];
						end
						csr_pkg::csr_mtvec:    m_view.mtvec <= upd.data[csr_pkg::xlen-1:2];
						csr_pkg::csr_mepc:     m_view.mepc <= {upd.data[csr_pkg::xlen-1:2], 2'b00};
						csr_pkg::csr_mcause:   m_view.mcause <= upd.data;
						csr_pkg::csr_mscratch: m_view.mscratch <= upd.data;
						csr_pkg::csr_medeleg:  m_view.medeleg <= upd.data[15:0];
						csr_pkg::csr_mideleg:  m_view.mideleg <= upd.data[11:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// return target while a return strobe is up, else the vector base
	always_comb
	begin
		case (upd.kind)
			csr_pkg::upd_mret: epc = m_view.mepc;
			csr_pkg::upd_sret: epc = sepc;
			default:           epc = {m_view.mtvec, 2'b00};
		endcase
	end

	assign irq_en = '{
		m_eie: m_view.meie & m_view.mie,
		m_tie: m_view.mtie & m_view.mie,
		s_eie: m_view.seie & s_sie,
		s_tie: m_view.stie & s_sie
	};

	mepc_aligned: assert property (@(posedge clk) disable iff (!nrst) m_view.mepc[1:0] == 2'b00)
	else $error("mepc lost its alignment");

endmodule

`default_nettype wire

// ==== design/priv_mode_ctrl.sv ====
`default_nettype none

module priv_mode_ctrl (
	input  logic                 clk,
	input  logic                 nrst,
	input  csr_pkg::trap_req_t   trap,
	input  csr_pkg::csr_update_t upd,
	input  csr_pkg::m_view_t     m_view,
	input  csr_pkg::s_view_t     s_view,
	output csr_pkg::priv_mode_e  target,
	output csr_pkg::priv_mode_e  current_mode
);

	logic [4:0] code;
	logic       deleg;

	assign code = trap.cause[4:0];

	always_comb
	begin
		if (trap.cause[csr_pkg::xlen-1])
			deleg = (code < csr_pkg::irq_deleg_n) && m_view.mideleg[code[3:0]];
		else
			deleg = (code < csr_pkg::exc_deleg_n) && m_view.medeleg[code[3:0]];
		// M mode never delegates downward
		if (current_mode == csr_pkg::mode_m || !deleg)
			target = csr_pkg::mode_m;
		else
			target = csr_pkg::mode_s;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			current_mode <= csr_pkg::mode_m;
		else
		begin
			case (upd.kind)
				csr_pkg::upd_trap: current_mode <= upd.target;
				csr_pkg::upd_mret: current_mode <= m_view.mpp;
				csr_pkg::upd_sret: current_mode <= s_view.spp ? csr_pkg::mode_s : csr_pkg::mode_u;
				default: ;
			endcase
		end
	end

	// covers mpp as written by software and by traps
	mode_legal: assert property (@(posedge clk) disable iff (!nrst) current_mode != 2'b10)
	else $error("current_mode entered the reserved encoding");

endmodule

`default_nettype wire

// ==== design/csr_update_arbiter.sv ====
`default_nettype none

module csr_update_arbiter (
	input  csr_pkg::csr_write_t  wr,
	input  csr_pkg::trap_req_t   trap,
	input  csr_pkg::priv_mode_e  target,
	output csr_pkg::csr_update_t upd
);

	always_comb
	begin
		upd.target = target;
		upd.addr   = wr.addr;
		upd.data   = wr.data;
		upd.cause  = trap.cause;
		upd.pc     = trap.pc_exc;
		// one winner per cycle, traps first
		if (trap.exception_pending)
			upd.kind = csr_pkg::upd_trap;
		else if (trap.m_ret)
			upd.kind = csr_pkg::upd_mret;
		else if (trap.s_ret)
			upd.kind = csr_pkg::upd_sret;
		else if (wr.we)
			upd.kind = csr_pkg::upd_write;
		else
			upd.kind = csr_pkg::upd_none;
	end

	// a return pair would silently drop sret
	always_comb
	begin
		assert (!(trap.m_ret && trap.s_ret))
		else $error("m_ret and s_ret high in the same cycle");
	end

endmodule

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

	parameter int xlen = 32;

	// delegation reach of medeleg and mideleg
	parameter int exc_deleg_n = 16;
	parameter int irq_deleg_n = 12;

	typedef enum logic [11:0] {
		csr_sstatus   = 12'h100,
		csr_sie       = 12'h104,
		csr_stvec     = 12'h105,
		csr_sscratch  = 12'h140,
		csr_sepc      = 12'h141,
		csr_scause    = 12'h142,
		csr_sip       = 12'h144,
		csr_mstatus   = 12'h300,
		csr_misa      = 12'h301,
		csr_medeleg   = 12'h302,
		csr_mideleg   = 12'h303,
		csr_mie       = 12'h304,
		csr_mtvec     = 12'h305,
		csr_mscratch  = 12'h340,
		csr_mepc      = 12'h341,
		csr_mcause    = 12'h342,
		csr_mip       = 12'h344,
		csr_stimecmp  = 12'h5c0,
		csr_mtimecmp  = 12'hbbf,
		csr_cycle     = 12'hc00,
		csr_time      = 12'hc01,
		csr_cycleh    = 12'hc80,
		csr_timeh     = 12'hc81,
		csr_mvendorid = 12'hf11,
		csr_marchid   = 12'hf12,
		csr_mimpid    = 12'hf13,
		csr_mhartid   = 12'hf14
	} csr_addr_e;

	typedef enum logic [1:0] {
		mode_u = 2'b00,
		mode_s = 2'b01,
		mode_m = 2'b11
	} priv_mode_e;

	typedef enum logic [2:0] {
		upd_none,
		upd_write,
		upd_trap,
		upd_mret,
		upd_sret
	} update_kind_e;

	// rv32 with a, i, m, s, u
	parameter logic [xlen-1:0] misa_value = 32'h4014_1101;

	// cause codes, bit 31 set for interrupts
	parameter logic [xlen-1:0] exc_illegal = 32'd2;
	parameter logic [xlen-1:0] exc_ecall_u = 32'd8;
	parameter logic [xlen-1:0] exc_ecall_s = 32'd9;
	parameter logic [xlen-1:0] irq_m_timer = 32'h8000_0007;

	typedef struct packed {
		logic            we;
		logic [11:0]     addr;
		logic [xlen-1:0] data;
	} csr_write_t;

	typedef struct packed {
		logic            exception_pending;
		logic [xlen-1:0] cause;
		logic [xlen-1:0] pc_exc;
		logic            m_ret;
		logic            s_ret;
	} trap_req_t;

	typedef struct packed {
		update_kind_e    kind;
		priv_mode_e      target;
		logic [11:0]     addr;
		logic [xlen-1:0] data;
		logic [xlen-1:0] cause;
		logic [xlen-1:0] pc;
	} csr_update_t;

	typedef struct packed {
		logic                   mie;
		logic                   mpie;
		priv_mode_e             mpp;
		logic                   sum;
		logic                   meie;
		logic                   mtie;
		logic                   seie;
		logic                   stie;
		logic [xlen-3:0]        mtvec;
		logic [xlen-1:0]        mepc;
		logic [xlen-1:0]        mcause;
		logic [xlen-1:0]        mscratch;
		logic [exc_deleg_n-1:0] medeleg;
		logic [irq_deleg_n-1:0] mideleg;
	} m_view_t;

	typedef struct packed {
		logic            sie;
		logic            spie;
		logic            spp;
		logic [xlen-3:0] stvec;
		logic [xlen-1:0] sepc;
		logic [xlen-1:0] scause;
		logic [xlen-1:0] sscratch;
	} s_view_t;

	typedef struct packed {
		logic m_eie;
		logic m_tie;
		logic s_eie;
		logic s_tie;
	} irq_enable_t;

endpackage

`default_nettype wire
